// File: Bender.yml
package:
  name: pipe_ctrl

sources:
  - files:
      - src/pipePkg.sv
      - src/stageTracker.sv
      - src/hazardUnit.sv
      - src/memBusArbiter.sv
      - src/pipeCtrlTop.sv
  - target: simulation
    files:
      - sim/clkGen.sv
      - sim/pipeCtrl_chk.sv
      - sim/pipeCtrlTb.sv

// File: sim/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen (
    output logic clk,
    output logic rstN
);
    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period.

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/pipeCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlTb;
    import pipePkg::*;

    typedef struct packed {
        ctrlSign     dm;
        ctrlSign     ds;
        regIdxT      rsM;
        regIdxT      rtM;
        regIdxT      rsS;
        regIdxT      rtS;
        logic [7:0]  lv;   // jumpM jumpS brM brS predTake mOnly sOnly lsBlank.
        logic [4:0]  ev;   // predFailM predFailS aluStall excM excS.
        stageVec     expStall;
        stageVec     expFlush;
    } rowT;

    logic clk;
    logic rstN;
    ctrlSign decMasterD;
    ctrlSign decSlaveD;
    regIdxT rsMasterD;
    regIdxT rtMasterD;
    regIdxT rsSlaveD;
    regIdxT rtSlaveD;
    logic jumpMasterD;
    logic jumpSlaveD;
    logic branchMasterD;
    logic branchSlaveD;
    logic predTakeD;
    logic masterOnlyOneD;
    logic slaveOnlyOneD;
    logic loadStoreBlank;
    logic predFailMasterE;
    logic predFailSlaveE;
    logic aluStallE;
    logic excMasterM;
    logic excSlaveM;
    logic iMissReq;
    logic dMissReq;
    logic busAck;
    stageVec stall;
    stageVec flush;
    fwdSelT fwdMasterRs;
    fwdSelT fwdMasterRt;
    fwdSelT fwdSlaveRs;
    fwdSelT fwdSlaveRt;
    logic busReq;
    logic busIsData;
    logic icacheCtl;

    rowT rows [$];
    ctrlSign mRec [0:3];   // E, M, M2, W.
    ctrlSign sRec [0:3];

    clkGen clkGen_i (.clk(clk), .rstN(rstN));

    pipeCtrlTop #(.DataFirst(1'b1)) pipeCtrlTop_i (.*);

    bind memBusArbiter pipeCtrl_chk chk_i (
        .clk(clk), .rstN(rstN), .busReq(busReq), .busIsData(busIsData), .busAck(busAck)
    );

    task automatic failNow(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            failNow($sformatf("Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic ctrlSign mkRec(input logic wr, input regIdxT r, input logic mr,
                                      input logic md);
        ctrlSign c;
        c = '0;
        c.regWrite = wr;
        c.writeReg = r;
        c.memRead = mr;
        c.divMulEn = md;
        return c;
    endfunction

    // search order slave E..W, then master E..W.
    function automatic fwdSelT expectFwd(input regIdxT src);
        ctrlSign r;
        if (src == '0) begin
            return '0;
        end
        for (int c = 8; c >= 1; c--) begin
            r = (c > 4) ? sRec[8 - c] : mRec[4 - c];
            if (r.regWrite && r.writeReg == src) begin
                return fwdSelT'(c);
            end
        end
        return '0;
    endfunction

    function automatic ctrlSign advance(input ctrlSign cur, input ctrlSign nxt,
                                        input logic hold, input logic fl);
        ctrlSign c;
        c = hold ? cur : nxt;
        if (fl) begin
            c = nxt;
            c.regWrite = 1'b0;
            c.memRead = 1'b0;
            c.isMfc0 = 1'b0;
        end
        return c;
    endfunction

    task automatic advanceModel(input rowT r);
        mRec[3] = advance(mRec[3], mRec[2], r.expStall.masterWb, r.expFlush.masterWb);
        sRec[3] = advance(sRec[3], sRec[2], r.expStall.slaveWb, r.expFlush.slaveWb);
        for (int s = 2; s >= 1; s--) begin
            mRec[s] = advance(mRec[s], mRec[s - 1], s == 2 ? r.expStall.mem2 : r.expStall.mem,
                              s == 2 ? r.expFlush.mem2 : r.expFlush.mem);
            sRec[s] = advance(sRec[s], sRec[s - 1], s == 2 ? r.expStall.mem2 : r.expStall.mem,
                              s == 2 ? r.expFlush.mem2 : r.expFlush.mem);
        end
        mRec[0] = advance(mRec[0], r.dm, r.expStall.exe, r.expFlush.exe);
        sRec[0] = advance(sRec[0], r.ds, r.expStall.exe, r.expFlush.exe);
    endtask

    task automatic addRow(input ctrlSign dm, input ctrlSign ds, input regIdxT rsM,
                          input regIdxT rtM, input regIdxT rsS, input regIdxT rtS,
                          input logic [7:0] lv, input logic [4:0] ev,
                          input stageVec es, input stageVec ef);
        rows.push_back(rowT'{dm, ds, rsM, rtM, rsS, rtS, lv, ev, es, ef});
    endtask

    task automatic buildTable();
        logic [31:0] seed;
        logic [31:0] ops;
        regIdxT wr;
        ctrlSign nop;
        nop = '0;
        seed = 32'h2544_d9ea;
        addRow(nop, mkRec(1, 7, 0, 0), 7, 0, 0, 0, 8'h00, 5'h00, 9'b0, 9'b0);
        addRow(mkRec(1, 7, 0, 0), mkRec(1, 0, 0, 0), 7, 0, 0, 0, 8'h00, 5'h00, 9'b0,
               9'b0);   // slave writes r0.
        addRow(mkRec(1, 9, 1, 0), nop, 7, 0, 7, 0, 8'h00, 5'h00, 9'b0, 9'b0);   // select 7.
        addRow(nop, nop, 9, 7, 0, 0, 8'h00, 5'h00, 9'b111100000, 9'b000010000);  // load-use.
        addRow(nop, nop, 9, 0, 0, 0, 8'h00, 5'h00, 9'b111100000, 9'b000010000);
        addRow(mkRec(1, 12, 0, 0), nop, 12, 9, 0, 0, 8'h00, 5'b00110, 9'b011111100,
               9'b011111100);   // exception during an alu stall.
        addRow(nop, nop, 12, 9, 0, 0, 8'h00, 5'h00, 9'b0, 9'b0);   // bubbled E gives 0.
        addRow(nop, nop, 0, 0, 0, 0, 8'b00101000, 5'h00, 9'b0, 9'b011100000);
        addRow(mkRec(1, 20, 0, 0), nop, 0, 0, 20, 0, 8'h00, 5'h00, 9'b110100000, 9'b001010000);
        addRow(mkRec(0, 0, 0, 1), mkRec(0, 0, 0, 1), 0, 0, 0, 0, 8'h00, 5'h00, 9'b0,
               9'b000010000);
        addRow(nop, nop, 0, 0, 0, 0, 8'b00000001, 5'h00, 9'b111111000, 9'b000000100);
        addRow(nop, nop, 0, 0, 0, 0, 8'h00, 5'b00100, 9'b111111111, 9'b0);
        addRow(nop, nop, 0, 0, 0, 0, 8'h00, 5'b10000, 9'b0, 9'b011110000);
        for (int k = 0; k < 8; k++) begin
            seed = lcgNext(seed);
            ops = seed;
            seed = lcgNext(seed);
            wr = seed[31:27];
            // no pairing conflict, so stalls stay low.
            addRow(mkRec(wr != ops[21:17] && wr != ops[16:12], wr, 0, 0),
                   mkRec(1, seed[26:22], 0, 0), ops[31:27], ops[26:22], ops[21:17],
                   ops[16:12], 8'h00, 5'h00, 9'b0, 9'b0);
        end
    endtask

    task automatic awaitGrant(input string what);
        int n;
        n = 0;
        while (!busReq && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!busReq) begin
            failNow({"timeout: no bus grant for the ", what, " refill"});
        end
    endtask

    task automatic runArbitration();
        @(negedge clk);
        {iMissReq, dMissReq} = 2'b11;
        #1 checkVal("stall", stall, 9'h1ff);
        checkVal("busReq", busReq, 0);
        awaitGrant("data");
        checkVal("busIsData", busIsData, 1);
        checkVal("stall", stall, 9'h1ff);
        checkVal("icacheCtl", icacheCtl, 1);
        repeat (2) @(negedge clk);
        busAck = 1'b1;
        #1 checkVal("stall", stall, 9'h1ff);   // instruction side still waits.
        @(negedge clk);
        {busAck, dMissReq} = 2'b00;
        #1 checkVal("busReq", busReq, 0);
        checkVal("stall", stall, 9'h1ff);
        checkVal("icacheCtl", icacheCtl, 0);   // only the instruction miss left.
        awaitGrant("instruction");
        checkVal("busIsData", busIsData, 0);
        busAck = 1'b1;
        #1 checkVal("stall", stall, 9'h0);
        @(negedge clk);
        {busAck, iMissReq} = 2'b00;
        #1 checkVal("busReq", busReq, 0);
        checkVal("stall", stall, 9'h0);
    endtask

    initial begin
        int n;
        {decMasterD, decSlaveD, rsMasterD, rtMasterD, rsSlaveD, rtSlaveD} = '0;
        {jumpMasterD, jumpSlaveD, branchMasterD, branchSlaveD, predTakeD} = '0;
        {masterOnlyOneD, slaveOnlyOneD, loadStoreBlank} = '0;
        {predFailMasterE, predFailSlaveE, aluStallE, excMasterM, excSlaveM} = '0;
        {iMissReq, dMissReq, busAck} = '0;
        mRec = '{default: '0};
        sRec = '{default: '0};
        buildTable();
        n = 0;
        while (!rstN && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!rstN) begin
            failNow("reset never released");
        end
        foreach (rows[i]) begin
            @(negedge clk);
            {decMasterD, decSlaveD} = {rows[i].dm, rows[i].ds};
            {rsMasterD, rtMasterD, rsSlaveD, rtSlaveD} =
                {rows[i].rsM, rows[i].rtM, rows[i].rsS, rows[i].rtS};
            {jumpMasterD, jumpSlaveD, branchMasterD, branchSlaveD, predTakeD,
             masterOnlyOneD, slaveOnlyOneD, loadStoreBlank} = rows[i].lv;
            {predFailMasterE, predFailSlaveE, aluStallE, excMasterM, excSlaveM} = rows[i].ev;
            #1;
            checkVal("fwdMasterRs", fwdMasterRs, expectFwd(rows[i].rsM));
            checkVal("fwdMasterRt", fwdMasterRt, expectFwd(rows[i].rtM));
            checkVal("fwdSlaveRs", fwdSlaveRs, expectFwd(rows[i].rsS));
            checkVal("fwdSlaveRt", fwdSlaveRt, expectFwd(rows[i].rtS));
            checkVal("stall", stall, rows[i].expStall);
            checkVal("flush", flush, rows[i].expFlush);
            // no cache miss here, so it follows fetch2.
            checkVal("icacheCtl", icacheCtl, rows[i].expStall.fetch2);
            checkVal("busReq", busReq, 0);
            @(posedge clk);
            advanceModel(rows[i]);
        end
        @(negedge clk);
        {decMasterD, decSlaveD, rsMasterD, rtMasterD, rsSlaveD, rtSlaveD} = '0;
        {predFailMasterE, predFailSlaveE, aluStallE, excMasterM, excSlaveM} = '0;
        {jumpMasterD, jumpSlaveD, branchMasterD, branchSlaveD, predTakeD} = '0;
        {masterOnlyOneD, slaveOnlyOneD, loadStoreBlank} = '0;
        runArbitration();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/pipeCtrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl_chk (
    input wire logic clk,
    input wire logic rstN,
    input wire logic busReq,
    input wire logic busIsData,
    input wire logic busAck
);
    // request and its type hold until the ack.
    holdReq: assert property (@(posedge clk) disable iff (!rstN)
        busReq && !busAck |=> busReq && $stable(busIsData))
        else $error("bus request or its type changed before busAck");

    dropAfterAck: assert property (@(posedge clk) disable iff (!rstN)
        busReq && busAck |=> !busReq)
        else $error("busReq still high in the cycle after busAck");

endmodule

`default_nettype wire

// File: sources.f
src/pipePkg.sv
src/stageTracker.sv
src/hazardUnit.sv
src/memBusArbiter.sv
src/pipeCtrlTop.sv
sim/clkGen.sv
sim/pipeCtrl_chk.sv
sim/pipeCtrlTb.sv

// File: src/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  pipePkg::ctrlSign decMasterD,
    input  pipePkg::ctrlSign decSlaveD,
    input  pipePkg::regIdxT  rsMasterD,
    input  pipePkg::regIdxT  rtMasterD,
    input  pipePkg::regIdxT  rsSlaveD,
    input  pipePkg::regIdxT  rtSlaveD,
    input  logic             jumpMasterD,
    input  logic             jumpSlaveD,
    input  logic             branchMasterD,
    input  logic             branchSlaveD,
    input  logic             predTakeD,
    input  logic             masterOnlyOneD,
    input  logic             slaveOnlyOneD,
    input  pipePkg::laneRecs recE,
    input  pipePkg::laneRecs recM,
    input  pipePkg::laneRecs recM2,
    input  pipePkg::laneRecs recW,
    input  logic             iCacheStall,
    input  logic             dCacheStall,
    input  logic             predFailMasterE,
    input  logic             predFailSlaveE,
    input  logic             excMasterM,
    input  logic             excSlaveM,
    input  logic             aluStallE,
    input  logic             loadStoreBlank,
    output pipePkg::fwdSelT  fwdMasterRs,
    output pipePkg::fwdSelT  fwdMasterRt,
    output pipePkg::fwdSelT  fwdSlaveRs,
    output pipePkg::fwdSelT  fwdSlaveRt,
    output pipePkg::stageVec stall,
    output pipePkg::stageVec flush,
    output logic             icacheCtl
);
    import pipePkg::*;

    ctrlSign cand [1:8];
    logic loadUse;
    logic onlyOne;
    logic cacheStall;
    logic longStall;
    logic excFlush;
    logic predFail;
    logic mulDivConflict;
    logic redirMaster;
    logic redirSlave;

    // higher code wins, so the last hit in ascending order is kept.
    function automatic fwdSelT pickSrc(input regIdxT src, input ctrlSign recs [1:8]);
        fwdSelT sel;
        sel = '0;
        if (src != '0) begin
            for (int i = 1; i <= 8; i++) begin
                if (recs[i].regWrite && recs[i].writeReg == src) begin
                    sel = fwdSelT'(i);
                end
            end
        end
        return sel;
    endfunction

    assign cand = '{recW.master, recM2.master, recM.master, recE.master,
                    recW.slave, recM2.slave, recM.slave, recE.slave};

    assign fwdMasterRs = pickSrc(rsMasterD, cand);
    assign fwdMasterRt = pickSrc(rtMasterD, cand);
    assign fwdSlaveRs = pickSrc(rsSlaveD, cand);
    assign fwdSlaveRt = pickSrc(rtSlaveD, cand);

    // load or mfc0 result not ready yet.
    assign loadUse = ((fwdMasterRs == 4'd4 || fwdMasterRt == 4'd4)
                      && (recE.master.memRead || recE.master.isMfc0))
                  || ((fwdMasterRs == 4'd3 || fwdMasterRt == 4'd3) && recM.master.memRead);

    // slave can't issue alongside the master.
    assign onlyOne = masterOnlyOneD || slaveOnlyOneD
                  || (decMasterD.regWrite && (rsSlaveD == decMasterD.writeReg
                                              || rtSlaveD == decMasterD.writeReg))
                  || (decSlaveD.hiloToReg && decMasterD.divMulEn);

    assign mulDivConflict = decMasterD.divMulEn && decSlaveD.divMulEn;
    assign cacheStall = iCacheStall || dCacheStall;
    assign longStall = cacheStall || aluStallE;
    assign excFlush = excMasterM || excSlaveM;
    assign predFail = predFailMasterE || predFailSlaveE;
    assign redirMaster = jumpMasterD || (branchMasterD && predTakeD);
    assign redirSlave = jumpSlaveD || (branchSlaveD && predTakeD);

    // instruction fetch keeps going while only the data side waits.
    assign icacheCtl = dCacheStall || aluStallE || loadUse || loadStoreBlank || onlyOne;

    always_comb begin
        stall.fetch2 = longStall || loadUse || loadStoreBlank || onlyOne;
        stall.fetch = !excFlush && stall.fetch2;   // exception redirect must fetch.
        stall.masterD = longStall || loadUse || loadStoreBlank;
        stall.slaveD = stall.masterD || onlyOne;
        stall.exe = longStall || loadStoreBlank;
        stall.mem = longStall || loadStoreBlank;
        stall.mem2 = longStall;
        stall.masterWb = longStall && !excFlush;
        stall.slaveWb = longStall && !excFlush;
    end

    always_comb begin
        flush.fetch = 1'b0;
        flush.fetch2 = excFlush || predFail || ((redirMaster || redirSlave) && !stall.fetch2);
        flush.masterD = excFlush || predFail || ((redirMaster || onlyOne) && !stall.masterD);
        flush.slaveD = excFlush || predFail || ((redirMaster || redirSlave) && !stall.slaveD);
        flush.exe = excFlush
                 || ((predFail || loadUse || onlyOne || mulDivConflict) && !stall.exe);
        flush.mem = excFlush;
        flush.mem2 = excFlush || (loadStoreBlank && !stall.mem2);
        flush.masterWb = 1'b0;
        flush.slaveWb = 1'b0;
    end

endmodule

`default_nettype wire

// File: src/memBusArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memBusArbiter #(
    parameter bit DataFirst = 1'b1   // data refill wins a tie.
) (
    input  logic clk,
    input  logic rstN,
    input  logic iMissReq,
    input  logic dMissReq,
    input  logic busAck,
    output logic busReq,
    output logic busIsData,
    output logic iCacheStall,
    output logic dCacheStall
);
    import pipePkg::*;

    arbState state;
    arbState nextState;
    logic pickData;
    logic iAcked;
    logic dAcked;

    assign pickData = dMissReq && (DataFirst || !iMissReq);

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (pickData) begin
                    nextState = serveData;
                end else if (iMissReq) begin
                    nextState = serveInstr;
                end
            end
            serveInstr,
            serveData: begin
                if (busAck) begin
                    nextState = idle;   // back through idle before the next grant.
                end
            end
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // request held for the whole grant, drops after the ack edge.
    assign busReq = (state != idle);
    assign busIsData = (state == serveData);

    assign iAcked = (state == serveInstr) && busAck;
    assign dAcked = (state == serveData) && busAck;

    // the side not being acknowledged keeps waiting.
    assign iCacheStall = iMissReq && !iAcked;
    assign dCacheStall = dMissReq && !dAcked;

endmodule

`default_nettype wire

// File: src/pipeCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlTop #(
    parameter bit DataFirst = 1'b1
) (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::ctrlSign decMasterD,
    input  pipePkg::ctrlSign decSlaveD,
    input  pipePkg::regIdxT  rsMasterD,
    input  pipePkg::regIdxT  rtMasterD,
    input  pipePkg::regIdxT  rsSlaveD,
    input  pipePkg::regIdxT  rtSlaveD,
    input  logic             jumpMasterD,
    input  logic             jumpSlaveD,
    input  logic             branchMasterD,
    input  logic             branchSlaveD,
    input  logic             predTakeD,
    input  logic             masterOnlyOneD,
    input  logic             slaveOnlyOneD,
    input  logic             loadStoreBlank,
    input  logic             predFailMasterE,
    input  logic             predFailSlaveE,
    input  logic             aluStallE,
    input  logic             excMasterM,
    input  logic             excSlaveM,
    input  logic             iMissReq,
    input  logic             dMissReq,
    input  logic             busAck,
    output pipePkg::stageVec stall,
    output pipePkg::stageVec flush,
    output pipePkg::fwdSelT  fwdMasterRs,
    output pipePkg::fwdSelT  fwdMasterRt,
    output pipePkg::fwdSelT  fwdSlaveRs,
    output pipePkg::fwdSelT  fwdSlaveRt,
    output logic             busReq,
    output logic             busIsData,
    output logic             icacheCtl
);
    import pipePkg::*;

    laneRecs recE;
    laneRecs recM;
    laneRecs recM2;
    laneRecs recW;
    logic iCacheStall;
    logic dCacheStall;

    stageTracker stageTracker_i (
        .clk        (clk),
        .rstN       (rstN),
        .decMasterD (decMasterD),
        .decSlaveD  (decSlaveD),
        .stall      (stall),
        .flush      (flush),
        .recE       (recE),
        .recM       (recM),
        .recM2      (recM2),
        .recW       (recW)
    );

    hazardUnit hazardUnit_i (
        .decMasterD      (decMasterD),
        .decSlaveD       (decSlaveD),
        .rsMasterD       (rsMasterD),
        .rtMasterD       (rtMasterD),
        .rsSlaveD        (rsSlaveD),
        .rtSlaveD        (rtSlaveD),
        .jumpMasterD     (jumpMasterD),
        .jumpSlaveD      (jumpSlaveD),
        .branchMasterD   (branchMasterD),
        .branchSlaveD    (branchSlaveD),
        .predTakeD       (predTakeD),
        .masterOnlyOneD  (masterOnlyOneD),
        .slaveOnlyOneD   (slaveOnlyOneD),
        .recE            (recE),
        .recM            (recM),
        .recM2           (recM2),
        .recW            (recW),
        .iCacheStall     (iCacheStall),
        .dCacheStall     (dCacheStall),
        .predFailMasterE (predFailMasterE),
        .predFailSlaveE  (predFailSlaveE),
        .excMasterM      (excMasterM),
        .excSlaveM       (excSlaveM),
        .aluStallE       (aluStallE),
        .loadStoreBlank  (loadStoreBlank),
        .fwdMasterRs     (fwdMasterRs),
        .fwdMasterRt     (fwdMasterRt),
        .fwdSlaveRs      (fwdSlaveRs),
        .fwdSlaveRt      (fwdSlaveRt),
        .stall           (stall),
        .flush           (flush),
        .icacheCtl       (icacheCtl)
    );

    memBusArbiter #(
        .DataFirst (DataFirst)
    ) memBusArbiter_i (
        .clk         (clk),
        .rstN        (rstN),
        .iMissReq    (iMissReq),
        .dMissReq    (dMissReq),
        .busAck      (busAck),
        .busReq      (busReq),
        .busIsData   (busIsData),
        .iCacheStall (iCacheStall),
        .dCacheStall (dCacheStall)
    );

endmodule

`default_nettype wire

// File: src/pipePkg.sv
`default_nettype none

package pipePkg;

    typedef logic [4:0] regIdxT;   // architectural register number.

    // 0 is the register file, 1..4 master W/M2/M/E, 5..8 slave W/M2/M/E.
    typedef logic [3:0] fwdSelT;

    typedef struct packed {
        logic   regWrite;
        regIdxT writeReg;
        logic   memRead;
        logic   isMfc0;
        logic   hiloToReg;   // mfhi/mflo reads the hilo pair.
        logic   divMulEn;
    } ctrlSign;

    // one bit per pipeline point, shared by the stall and flush buses.
    typedef struct packed {
        logic fetch;
        logic fetch2;
        logic masterD;
        logic slaveD;
        logic exe;
        logic mem;
        logic mem2;
        logic masterWb;
        logic slaveWb;
    } stageVec;

    typedef struct packed {
        ctrlSign master;
        ctrlSign slave;
    } laneRecs;

    typedef enum logic [1:0] {
        idle,
        serveInstr,
        serveData
    } arbState;

endpackage

`default_nettype wire

// File: src/stageTracker.sv
`timescale 1ns/1ps
`default_nettype none

module stageTracker (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::ctrlSign decMasterD,
    input  pipePkg::ctrlSign decSlaveD,
    input  pipePkg::stageVec stall,
    input  pipePkg::stageVec flush,
    output pipePkg::laneRecs recE,
    output pipePkg::laneRecs recM,
    output pipePkg::laneRecs recM2,
    output pipePkg::laneRecs recW
);
    import pipePkg::*;

    // incoming record with its side effects removed.
    function automatic ctrlSign bubble(input ctrlSign rec);
        ctrlSign b;
        b = rec;
        b.regWrite = 1'b0;
        b.isMfc0 = 1'b0;
        b.memRead = 1'b0;
        return b;
    endfunction

    // next value of one lane slot, flush beats stall.
    function automatic ctrlSign step(
        input ctrlSign cur,
        input ctrlSign nxt,
        input logic    holdBit,
        input logic    flushBit
    );
        ctrlSign r;
        if (flushBit) begin
            r = bubble(nxt);
        end else if (holdBit) begin
            r = cur;
        end else begin
            r = nxt;
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            recE <= '0;
            recM <= '0;
            recM2 <= '0;
            recW <= '0;
        end else begin
            recE.master <= step(recE.master, decMasterD, stall.exe, flush.exe);
            recE.slave <= step(recE.slave, decSlaveD, stall.exe, flush.exe);

            recM.master <= step(recM.master, recE.master, stall.mem, flush.mem);
            recM.slave <= step(recM.slave, recE.slave, stall.mem, flush.mem);

            recM2.master <= step(recM2.master, recM.master, stall.mem2, flush.mem2);
            recM2.slave <= step(recM2.slave, recM.slave, stall.mem2, flush.mem2);

            // writeback lanes hold independently.
            recW.master <= step(recW.master, recM2.master, stall.masterWb, flush.masterWb);
            recW.slave <= step(recW.slave, recM2.slave, stall.slaveWb, flush.slaveWb);
        end
    end

endmodule

`default_nettype wire
